// ==== rtl/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

`define DataWidth 32
`define AddrWidth 32
`define RegNumWidth 5
`define MemWords 64 // data memory depth in words

// RV32I major opcodes, all zeros is a bubble
`define OpR 7'b0110011
`define OpImm 7'b0010011
`define OpLoad 7'b0000011
`define OpStore 7'b0100011
`define OpBranch 7'b1100011
`define OpJal 7'b1101111
`define OpJalr 7'b1100111
`define OpLui 7'b0110111
`define OpAuipc 7'b0010111

`endif

// ==== rtl/corePkg.sv ====
package corePkg;

	typedef enum logic [4:0]
	{
		aluAdd,
		aluSub,
		aluSll,
		aluSrl,
		aluSra,
		aluSlt, // set-less signed
		aluSltu, // set-less unsigned
		aluXor,
		aluOr,
		aluAnd,
		aluEq,
		aluNe,
		aluGe, // greater-or-equal signed
		aluGeu // greater-or-equal unsigned
	} aluOpT;

	// what the memory stage does with an executed instruction
	typedef enum logic [2:0]
	{
		actIdle,
		actRegWrite,
		actMemReadRegWrite,
		actMemWrite,
		actBranch,
		actJump, // jal and jalr
		actLuiWrite
	} actionT;

	function automatic logic writesReg(input actionT action);
		return action inside {actRegWrite, actMemReadRegWrite, actJump, actLuiWrite};
	endfunction

endpackage

// ==== rtl/execBus.sv ====
`include "core_defines.svh"

interface execBus;
	corePkg::actionT action;
	logic [`RegNumWidth-1:0] rd;
	logic [`AddrWidth-1:0] pc;
	logic [`DataWidth-1:0] imm;
	logic [`DataWidth-1:0] aluResult; // address, compare flag or jump target
	logic [`DataWidth-1:0] storeData; // forwarded rs2
	logic [2:0] func3;

	modport exec (output action, rd, pc, imm, aluResult, storeData, func3);
	modport mem (input action, rd, pc, imm, aluResult, storeData, func3);
	modport fwd (input action, rd);
endinterface

// ==== rtl/alu.sv ====
`include "core_defines.svh"

module alu
(
	input corePkg::aluOpT op,
	input logic [`DataWidth-1:0] x,
	input logic [`DataWidth-1:0] y,
	output logic [`DataWidth-1:0] result
);

	logic [4:0] shamt;

	assign shamt = y[4:0]; // shifts use low five bits only

	always_comb
	begin
		case (op)
			corePkg::aluAdd: result = x + y;
			corePkg::aluSub: result = x - y;
			corePkg::aluSll: result = x << shamt;
			corePkg::aluSrl: result = x >> shamt;
			corePkg::aluSra: result = $signed(x) >>> shamt;
			corePkg::aluSlt: result = {31'b0, $signed(x) < $signed(y)};
			corePkg::aluSltu: result = {31'b0, x < y};
			corePkg::aluXor: result = x ^ y;
			corePkg::aluOr: result = x | y;
			corePkg::aluAnd: result = x & y;
			corePkg::aluEq: result = {31'b0, x == y};
			corePkg::aluNe: result = {31'b0, x != y};
			corePkg::aluGe: result = {31'b0, $signed(x) >= $signed(y)};
			corePkg::aluGeu: result = {31'b0, x >= y};
			default: result = '0;
		endcase
	end

endmodule

// ==== rtl/regFile.sv ====
`include "core_defines.svh"

module regFile
(
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input logic [`RegNumWidth-1:0] writeNum,
	input logic [`DataWidth-1:0] writeData,
	input logic [`RegNumWidth-1:0] readNumA,
	input logic [`RegNumWidth-1:0] readNumB,
	input logic [`RegNumWidth-1:0] watchNum,
	output logic [`DataWidth-1:0] readDataA,
	output logic [`DataWidth-1:0] readDataB,
	output logic [`DataWidth-1:0] watchData
);

	logic [`DataWidth-1:0] regs [32];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && writeNum != '0)
			regs[writeNum] <= writeData; // x0 never written
	end

	// no write-through, a write shows up the cycle after
	assign readDataA = (readNumA == '0) ? '0 : regs[readNumA];
	assign readDataB = (readNumB == '0) ? '0 : regs[readNumB];
	assign watchData = (watchNum == '0) ? '0 : regs[watchNum];

endmodule

// ==== rtl/forwardUnit.sv ====
`include "core_defines.svh"

module forwardUnit
(
	input logic [`RegNumWidth-1:0] readNumA,
	input logic [`RegNumWidth-1:0] readNumB,
	input logic wbEnable,
	input logic [`RegNumWidth-1:0] wbNum,
	execBus.fwd bus,
	output logic [1:0] fwdSelA,
	output logic [1:0] fwdSelB
);

	logic memValid;
	logic wbValid;

	// only sources that really write a nonzero register count
	assign memValid = corePkg::writesReg(bus.action) && bus.rd != '0;
	assign wbValid = wbEnable && wbNum != '0;

	// memory stage is younger, so it wins over writeback
	assign fwdSelA = (memValid && bus.rd == readNumA) ? 2'd1 :
		(wbValid && wbNum == readNumA) ? 2'd2 : 2'd0;
	assign fwdSelB = (memValid && bus.rd == readNumB) ? 2'd1 :
		(wbValid && wbNum == readNumB) ? 2'd2 : 2'd0;

endmodule

// ==== rtl/execute.sv ====
`include "core_defines.svh"

module execute
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic [`AddrWidth-1:0] pc,
	input logic [`DataWidth-1:0] imm,
	input logic [2:0] func3,
	input logic [6:0] func7,
	input logic [6:0] opcode,
	input logic [`RegNumWidth-1:0] rs1,
	input logic [`RegNumWidth-1:0] rs2,
	input logic [`RegNumWidth-1:0] rd,
	input logic [`DataWidth-1:0] regDataA,
	input logic [`DataWidth-1:0] regDataB,
	input logic [1:0] fwdSelA,
	input logic [1:0] fwdSelB,
	input logic [`DataWidth-1:0] fwdData,
	input logic [`DataWidth-1:0] wbData,
	output logic [`DataWidth-1:0] aluWatch,
	execBus.exec bus
);

	corePkg::aluOpT aluOp;
	corePkg::actionT nextAction;
	logic [`DataWidth-1:0] opA, opB;
	logic [`DataWidth-1:0] aluX, aluY;
	logic [`DataWidth-1:0] aluOut;
	logic altBit;

	function automatic logic [`DataWidth-1:0] pickSource(input logic [1:0] sel,
		input logic [`DataWidth-1:0] fromRegs);
		case (sel)
			2'd1: return fwdData; // instruction in memory stage
			2'd2: return wbData; // instruction in writeback
			default: return fromRegs;
		endcase
	endfunction

	// x0 guard covers forwarded sources too
	assign opA = (rs1 == '0) ? '0 : pickSource(fwdSelA, regDataA);
	assign opB = (rs2 == '0) ? '0 : pickSource(fwdSelB, regDataB);
	assign altBit = (opcode == `OpR) ? func7[5] : imm[10]; // sub/sra vs srai

	always_comb
	begin
		aluOp = corePkg::aluAdd;
		aluX = opA;
		aluY = imm;
		nextAction = corePkg::actIdle;
		case (opcode)
			`OpR, `OpImm:
			begin
				if (opcode == `OpR)
					aluY = opB;
				case (func3)
					3'd0: aluOp = (opcode == `OpR && func7[5]) ? corePkg::aluSub : corePkg::aluAdd;
					3'd1: aluOp = corePkg::aluSll;
					3'd2: aluOp = corePkg::aluSlt;
					3'd3: aluOp = corePkg::aluSltu;
					3'd4: aluOp = corePkg::aluXor;
					3'd5: aluOp = altBit ? corePkg::aluSra : corePkg::aluSrl;
					3'd6: aluOp = corePkg::aluOr;
					default: aluOp = corePkg::aluAnd;
				endcase
				nextAction = corePkg::actRegWrite;
			end
			`OpLoad: nextAction = corePkg::actMemReadRegWrite; // rs1 + imm
			`OpStore: nextAction = corePkg::actMemWrite;
			`OpBranch:
			begin
				aluY = opB;
				nextAction = corePkg::actBranch;
				case (func3)
					3'd0: aluOp = corePkg::aluEq;
					3'd1: aluOp = corePkg::aluNe;
					3'd4: aluOp = corePkg::aluSlt;
					3'd5: aluOp = corePkg::aluGe;
					3'd6: aluOp = corePkg::aluSltu;
					3'd7: aluOp = corePkg::aluGeu;
					default: nextAction = corePkg::actIdle; // no such branch
				endcase
			end
			`OpJal:
			begin
				aluX = pc; // target pc + imm
				nextAction = corePkg::actJump;
			end
			`OpJalr: nextAction = corePkg::actJump; // target rs1 + imm
			`OpLui: nextAction = corePkg::actLuiWrite;
			`OpAuipc:
			begin
				aluX = pc;
				nextAction = corePkg::actRegWrite;
			end
			default: nextAction = corePkg::actIdle; // bubble or unknown
		endcase
	end

	alu aluInst
	(
		.op(aluOp),
		.x(aluX),
		.y(aluY),
		.result(aluOut)
	);

	assign aluWatch = aluOut;

	always_ff @(posedge clk)
	begin
		if (reset)
			bus.action <= corePkg::actIdle;
		else
			bus.action <= flush ? corePkg::actIdle : nextAction;
	end

	always_ff @(posedge clk)
	begin
		bus.rd <= rd;
		bus.pc <= pc;
		bus.imm <= imm;
		bus.aluResult <= aluOut;
		bus.storeData <= opB;
		bus.func3 <= func3;
	end

endmodule

// ==== rtl/memStage.sv ====
`include "core_defines.svh"

module memStage
(
	input logic clk,
	input logic reset,
	input logic [`AddrWidth-1:0] memWatchAddr, // byte address
	execBus.mem bus,
	output logic [`DataWidth-1:0] fwdData,
	output logic wbEnable,
	output logic [`RegNumWidth-1:0] wbNum,
	output logic [`DataWidth-1:0] wbData,
	output logic pcWriteEnable,
	output logic [`AddrWidth-1:0] pcWriteData,
	output logic [`DataWidth-1:0] memWatchData
);

	localparam int MemIdxBits = $clog2(`MemWords);

	logic [`DataWidth-1:0] mem [`MemWords];
	logic [MemIdxBits-1:0] memIdx;
	logic [`DataWidth-1:0] loadData;
	logic [`AddrWidth-1:0] linkAddr;
	logic taken;

	assign memIdx = bus.aluResult[2 +: MemIdxBits]; // word index of the byte address
	assign loadData = mem[memIdx]; // asynchronous read
	assign memWatchData = mem[memWatchAddr[2 +: MemIdxBits]];

	// only the word store is kept
	always_ff @(posedge clk)
	begin
		if (bus.action == corePkg::actMemWrite && bus.func3 == 3'b010)
			mem[memIdx] <= bus.storeData;
	end

	assign linkAddr = bus.pc + `AddrWidth'd4;
	assign taken = bus.action == corePkg::actBranch && bus.aluResult[0];
	assign pcWriteEnable = taken || bus.action == corePkg::actJump;
	assign pcWriteData = taken ? bus.pc + bus.imm : {bus.aluResult[`AddrWidth-1:1], 1'b0};

	always_comb
	begin
		case (bus.action)
			corePkg::actMemReadRegWrite: fwdData = loadData;
			corePkg::actJump: fwdData = linkAddr;
			corePkg::actLuiWrite: fwdData = bus.imm;
			default: fwdData = bus.aluResult;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			wbEnable <= 1'b0;
		else
			wbEnable <= corePkg::writesReg(bus.action);
	end

	always_ff @(posedge clk)
	begin
		wbNum <= bus.rd;
		wbData <= fwdData;
	end

endmodule

// ==== rtl/executeTop.sv ====
`include "core_defines.svh"

module executeTop
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic [`AddrWidth-1:0] pc,
	input logic [`DataWidth-1:0] imm,
	input logic [2:0] func3,
	input logic [6:0] func7,
	input logic [6:0] opcode,
	input logic [`RegNumWidth-1:0] rs1,
	input logic [`RegNumWidth-1:0] rs2,
	input logic [`RegNumWidth-1:0] rd,
	input logic [`RegNumWidth-1:0] regWatchNum,
	input logic [`AddrWidth-1:0] memWatchAddr,
	output logic pcWriteEnable,
	output logic [`AddrWidth-1:0] pcWriteData,
	output logic [`DataWidth-1:0] regWatchData,
	output logic [`DataWidth-1:0] aluWatch,
	output logic [`DataWidth-1:0] memWatchData
);

	logic [`DataWidth-1:0] regDataA, regDataB;
	logic [1:0] fwdSelA, fwdSelB;
	logic [`DataWidth-1:0] fwdData;
	logic wbEnable;
	logic [`RegNumWidth-1:0] wbNum;
	logic [`DataWidth-1:0] wbData;

	execBus exBus();

	regFile rf
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(wbEnable),
		.writeNum(wbNum),
		.writeData(wbData),
		.readNumA(rs1),
		.readNumB(rs2),
		.watchNum(regWatchNum),
		.readDataA(regDataA),
		.readDataB(regDataB),
		.watchData(regWatchData)
	);

	forwardUnit fwdUnit
	(
		.readNumA(rs1),
		.readNumB(rs2),
		.wbEnable(wbEnable),
		.wbNum(wbNum),
		.bus(exBus.fwd),
		.fwdSelA(fwdSelA),
		.fwdSelB(fwdSelB)
	);

	execute exec
	(
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.pc(pc),
		.imm(imm),
		.func3(func3),
		.func7(func7),
		.opcode(opcode),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.regDataA(regDataA),
		.regDataB(regDataB),
		.fwdSelA(fwdSelA),
		.fwdSelB(fwdSelB),
		.fwdData(fwdData),
		.wbData(wbData),
		.aluWatch(aluWatch),
		.bus(exBus.exec)
	);

	memStage mem
	(
		.clk(clk),
		.reset(reset),
		.memWatchAddr(memWatchAddr),
		.bus(exBus.mem),
		.fwdData(fwdData),
		.wbEnable(wbEnable),
		.wbNum(wbNum),
		.wbData(wbData),
		.pcWriteEnable(pcWriteEnable),
		.pcWriteData(pcWriteData),
		.memWatchData(memWatchData)
	);

endmodule

// ==== verification/execute_checker.sv ====
`include "core_defines.svh"

module executeChecker
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic pcWriteEnable,
	input logic [`AddrWidth-1:0] pcWriteData
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0; // read by the testbench at the end

	quietAfterReset: assert property (@(posedge clk) reset |=> !pcWriteEnable)
	else
	begin
		failCount++;
		$error("redirect raised in the cycle after reset");
	end

	flushNoRedirect: assert property (@(posedge clk) disable iff (reset)
		flush |=> !pcWriteEnable)
	else
	begin
		failCount++;
		$error("redirect raised by a flushed instruction");
	end

	// targets are always at least halfword aligned
	alignedTarget: assert property (@(posedge clk) disable iff (reset)
		pcWriteEnable |-> !pcWriteData[0])
	else
	begin
		failCount++;
		$error("redirect target has bit 0 set");
	end

endmodule

bind executeTop executeChecker checks
(
	.clk(clk),
	.reset(reset),
	.flush(flush),
	.pcWriteEnable(pcWriteEnable),
	.pcWriteData(pcWriteData)
);

// ==== verification/executeTb.sv ====
`include "core_defines.svh"

module executeTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int AluCount = 80;
	localparam int MemCount = 12;
	localparam int TotalCycles = 2 + 2 * (3 + 32) + 18 + AluCount + 3 * MemCount + 40 + 20
		+ `MemWords;

	logic clk = 1'b0;
	logic reset, flush;
	logic [`AddrWidth-1:0] pc, memWatchAddr, pcWriteData;
	logic [`DataWidth-1:0] imm, regWatchData, aluWatch, memWatchData;
	logic [2:0] func3;
	logic [6:0] func7, opcode;
	logic [`RegNumWidth-1:0] rs1, rs2, rd, regWatchNum;
	logic pcWriteEnable;

	logic [`DataWidth-1:0] modelRegs [32];
	logic [`DataWidth-1:0] modelMem [`MemWords];
	bit written [`MemWords]; // only stored words are compared
	logic [`AddrWidth-1:0] nextPc = 32'h0000_1000;
	logic [31:0] rng = 32'h581d_eb0e;
	logic issueEn = 1'b0;
	logic expEn = 1'b0;
	logic [`AddrWidth-1:0] issueTarget = '0;
	logic [`AddrWidth-1:0] expTarget = '0;
	logic aluEn = 1'b0;
	logic [`DataWidth-1:0] aluExpected = '0;
	bit [2:0] branchTypes [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
	int errors = 0;
	int checks = 0;

	executeTop UUT (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		return v ^ (v << 5);
	endfunction

	function automatic logic [31:0] nextRandom();
		rng = xorshift(rng);
		return rng;
	endfunction

	// RV32I arithmetic by funct3, alt selects sub or sra
	function automatic logic [31:0] aluModel(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5:
			begin
				if (alt)
					return $signed(a) >>> b[4:0];
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic bit branchModel(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic expectValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected)
		else
		begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	// drives one instruction for a cycle and updates the reference model
	task automatic issue(input logic [6:0] op, input logic [2:0] f3, input logic alt,
		input logic [4:0] s1, input logic [4:0] s2, input logic [4:0] d,
		input logic [31:0] im, input logic fl);
		logic [31:0] a, b, addr, result, target;
		logic writes, redirect, aluCheck;
		@(posedge clk);
		opcode <= op;
		func3 <= f3;
		func7 <= alt ? 7'h20 : 7'h00;
		rs1 <= s1;
		rs2 <= s2;
		rd <= d;
		imm <= im;
		pc <= nextPc;
		flush <= fl;
		a = modelRegs[s1];
		b = modelRegs[s2];
		addr = a + im;
		result = '0;
		target = nextPc + im;
		writes = !fl && op inside {`OpR, `OpImm, `OpLoad, `OpJal, `OpJalr, `OpLui, `OpAuipc};
		redirect = 1'b0;
		if (!fl)
		begin
			case (op)
				`OpR: result = aluModel(f3, alt, a, b);
				`OpImm: result = aluModel(f3, f3 == 3'd5 && im[10], a, im); // srai by imm bit 10
				`OpLoad: result = modelMem[addr[7:2]];
				`OpBranch: redirect = branchModel(f3, a, b);
				`OpLui: result = im;
				`OpAuipc: result = nextPc + im;
				default: result = nextPc + 4; // link value of jal and jalr
			endcase
			if (op == `OpStore)
			begin
				modelMem[addr[7:2]] = b;
				written[addr[7:2]] = 1'b1;
			end
			if (op == `OpJal || op == `OpJalr)
				redirect = 1'b1;
			if (op == `OpJalr)
				target = addr & 32'hffff_fffe;
		end
		aluCheck = !fl && op inside {`OpR, `OpImm, `OpLoad, `OpStore};
		if (writes && d != 5'd0)
			modelRegs[d] = result;
		issueEn <= redirect;
		issueTarget <= target;
		aluEn <= aluCheck;
		aluExpected <= (op == `OpR || op == `OpImm) ? result : addr; // lw and sw address
		nextPc = nextPc + 4;
	endtask

	task automatic bubbles(input int count);
		repeat (count) issue(7'd0, 3'd0, 1'b0, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0);
	endtask

	// wrong-path instruction behind a redirect, flushed by the environment
	task automatic wrongPath();
		issue(`OpR, 3'd0, 1'b0, 5'd8, 5'd9, 5'd1, 32'h0, 1'b1);
	endtask

	task automatic checkRegs(input string name);
		bubbles(3); // let writeback reach the register file
		for (int r = 0; r < 32; r++)
		begin
			@(posedge clk);
			regWatchNum <= 5'(r);
			@(negedge clk);
			expectValue($sformatf("%s x%0d", name, r), modelRegs[r], regWatchData);
		end
	endtask

	task automatic checkMem(input string name);
		for (int w = 0; w < `MemWords; w++)
		begin
			if (written[w])
			begin
				@(posedge clk);
				memWatchAddr <= 32'(w * 4);
				@(negedge clk);
				expectValue($sformatf("%s word %0d", name, w), modelMem[w], memWatchData);
			end
		end
	endtask

	// redirect is due one cycle after issue
	always @(posedge clk)
	begin
		expEn <= issueEn;
		expTarget <= issueTarget;
	end

	always @(negedge clk)
	begin
		if (!reset)
		begin
			expectValue("redirect enable", {31'b0, expEn}, {31'b0, pcWriteEnable});
			if (expEn)
				expectValue("redirect target", expTarget, pcWriteData);
			if (aluEn)
				expectValue("alu output", aluExpected, aluWatch); // same cycle as issue
		end
	end

	initial
	begin
		#(TotalCycles * 20 + 2000);
		$display("timeout, the test sequence did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

	initial
	begin
		logic [31:0] word, im;
		logic [2:0] f3;
		logic alt;
		int total;
		reset = 1'b1;
		flush = 1'b0;
		pc = '0;
		imm = '0;
		func3 = '0;
		func7 = '0;
		opcode = '0;
		rs1 = '0;
		rs2 = '0;
		rd = '0;
		regWatchNum = '0;
		memWatchAddr = '0;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		checkRegs("after reset");

		for (int r = 1; r < 16; r++)
			issue(`OpLui, 3'd0, 1'b0, 5'd0, 5'd0, 5'(r), nextRandom() & 32'hffff_f000, 1'b0);
		for (int n = 0; n < AluCount; n++)
		begin
			word = nextRandom();
			f3 = word[2:0];
			alt = word[3] && (f3 == 3'd0 || f3 == 3'd5);
			im = {{20{word[31]}}, word[31:20]};
			if (!word[4] && (f3 == 3'd1 || f3 == 3'd5))
				im = {21'b0, alt, 5'b0, word[24:20]}; // shift amount only
			issue(word[4] ? `OpR : `OpImm, f3, alt, 5'(word[10:8]), 5'(word[13:11]),
				5'(word[16:14]), im, 1'b0);
		end
		issue(`OpImm, 3'd0, 1'b0, 5'd0, 5'd0, 5'd5, 32'd1, 1'b0);
		issue(`OpImm, 3'd0, 1'b0, 5'd0, 5'd0, 5'd5, 32'd2, 1'b0);
		issue(`OpR, 3'd0, 1'b0, 5'd5, 5'd5, 5'd6, 32'h0, 1'b0); // younger x5 must win

		issue(`OpStore, 3'd2, 1'b0, 5'd0, 5'd9, 5'd0, 32'h0, 1'b0);
		issue(`OpLoad, 3'd2, 1'b0, 5'd0, 5'd0, 5'd0, 32'h0, 1'b0); // load into x0
		for (int n = 0; n < MemCount; n++)
		begin
			word = nextRandom();
			im = {{20{word[31]}}, word[31:20]};
			issue(`OpStore, 3'd2, 1'b0, 5'(word[2:0]), 5'(word[5:3]), 5'd0, im, 1'b0);
			issue(`OpLoad, 3'd2, 1'b0, 5'(word[2:0]), 5'd0, 5'(word[8:6]), im, 1'b0);
			issue(`OpR, 3'd0, 1'b0, 5'(word[8:6]), 5'(word[11:9]), 5'(word[14:12]), 32'h0, 1'b0);
		end

		issue(`OpLui, 3'd0, 1'b0, 5'd0, 5'd0, 5'd8, 32'h8000_0000, 1'b0); // negative operand
		issue(`OpLui, 3'd0, 1'b0, 5'd0, 5'd0, 5'd9, 32'h0000_5000, 1'b0);
		for (int n = 0; n < 6; n++)
		begin
			issue(`OpBranch, branchTypes[n], 1'b0, 5'd8, 5'd8, 5'd0, 32'h0000_0040, 1'b0);
			wrongPath();
			issue(`OpBranch, branchTypes[n], 1'b0, 5'd8, 5'd9, 5'd0, 32'hffff_ffe0, 1'b0);
			wrongPath();
			issue(`OpBranch, branchTypes[n], 1'b0, 5'd9, 5'd8, 5'd0, 32'h0000_0100, 1'b0);
			wrongPath();
		end

		issue(`OpJal, 3'd0, 1'b0, 5'd0, 5'd0, 5'd10, 32'h0000_0800, 1'b0);
		wrongPath();
		issue(`OpJalr, 3'd0, 1'b0, 5'd9, 5'd0, 5'd11, 32'h0000_0013, 1'b0); // odd sum
		wrongPath();
		issue(`OpJalr, 3'd0, 1'b0, 5'd11, 5'd0, 5'd12, 32'hffff_fffc, 1'b0);
		wrongPath();
		issue(`OpAuipc, 3'd0, 1'b0, 5'd0, 5'd0, 5'd13, 32'h0001_2000, 1'b0);
		issue(`OpLui, 3'd0, 1'b0, 5'd0, 5'd0, 5'd14, nextRandom() & 32'hffff_f000, 1'b0);
		issue(`OpR, 3'd0, 1'b0, 5'd13, 5'd14, 5'd15, 32'h0, 1'b0);

		issue(`OpStore, 3'd2, 1'b0, 5'd0, 5'd8, 5'd0, 32'h0, 1'b1);
		issue(`OpBranch, 3'd0, 1'b0, 5'd8, 5'd8, 5'd0, 32'h0000_0040, 1'b1);
		issue(`OpJal, 3'd0, 1'b0, 5'd0, 5'd0, 5'd10, 32'h0000_0200, 1'b1);
		issue(`OpLui, 3'd0, 1'b0, 5'd0, 5'd0, 5'd8, 32'h1234_5000, 1'b1);

		checkRegs("final register");
		checkMem("final memory");
		total = errors + UUT.checks.failCount;
		$display("checks %0d, value errors %0d, assertion failures %0d",
			checks, errors, UUT.checks.failCount);
		if (total == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/corePkg.sv
rtl/execBus.sv
rtl/alu.sv
rtl/regFile.sv
rtl/forwardUnit.sv
rtl/execute.sv
rtl/memStage.sv
rtl/executeTop.sv
verification/execute_checker.sv
verification/executeTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the execute subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
	--top-module executeTb -Mdir obj_dir -o executeSim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/executeSim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TESTBENCH PASSED$" sim.log; then
	exit 0
fi
exit 1
